// File: Bender.yml
package:
  name: pce_loader

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pce_loader_pkg.sv
      - rtl/populous_detect.sv
      - rtl/rom_writer.sv
      - rtl/cheat_code_assembler.sv
      - rtl/cd_data_unpacker.sv
      - rtl/pce_loader.sv

  - target: simulation
    include_dirs:
      - rtl
      - sim
    files:
      - sim/tb_pce_loader.sv

// File: filelist.f
+incdir+rtl
+incdir+sim
rtl/pce_loader_pkg.sv
rtl/populous_detect.sv
rtl/rom_writer.sv
rtl/cheat_code_assembler.sv
rtl/cd_data_unpacker.sv
rtl/pce_loader.sv
sim/tb_pce_loader.sv

// File: rtl/cd_data_unpacker.sv
/*
 * CD data unpacker, reads the download header then emits bytes
 * low first with one write strobe each
 */
`timescale 1ns/10ps
`include "pce_loader_settings.svh"

module cd_data_unpacker (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  pce_loader_pkg::ioctl_bus_t ioctl,
	output pce_loader_pkg::cd_byte_t   cd_byte,
	output logic                       cd_wr
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ARM,
		S_STROBE
	} state_t;

	pce_loader_pkg::cd_word_u word;
	state_t                   state;
	logic                     cd_download;
	logic                     cd_download_d;
	logic                     load_start;
	logic                     data_wr;
	logic                     hdr_wr;
	logic                     dat_wr;
	logic                     head_pos;
	logic                     byte_sel;
	logic                     dm;
	logic [`LDR_CD_LEN_W-1:0] len;
	logic [`LDR_CD_LEN_W-1:0] cnt;
	logic [`LDR_CD_LEN_W-1:0] cnt_next;
	logic [7:0]               lo_byte;
	logic [7:0]               hi_byte;

	assign word        = ioctl.dout;
	assign cd_download = ioctl.download && (ioctl.index[5:0] == `LDR_IDX_CD_DATA);
	assign load_start  = cd_download && !cd_download_d;
	assign data_wr     = cd_download && ioctl.wr && !load_start;
	assign hdr_wr      = data_wr && !head_pos;
	assign dat_wr      = data_wr && head_pos && (cnt < len);
	assign cnt_next    = cnt + `LDR_CD_LEN_W'(1);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cd_download_d <= 1'b0;
			head_pos      <= 1'b0;
			len           <= '0;
			cnt           <= '0;
			byte_sel      <= 1'b0;
			state         <= S_IDLE;
		end else begin
			cd_download_d <= cd_download;
			if (load_start) begin
				head_pos <= 1'b0;
				len      <= '0;
				cnt      <= '0;
				state    <= S_IDLE;
			end else begin
				if (hdr_wr) begin
					head_pos <= 1'b1;
					len      <= word.hdr.len;
					cnt      <= '0;
				end else if (dat_wr) begin
					byte_sel <= 1'b0;
					state    <= S_ARM;
				end
				case (state)
					S_ARM: state <= S_STROBE;
					S_STROBE: begin
						cnt      <= cnt_next;
						byte_sel <= ~byte_sel;
						// Odd length ends on a low byte
						state <= (byte_sel || (cnt_next == len)) ? S_IDLE : S_ARM;
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (hdr_wr) begin
			dm <= word.hdr.dm;
		end
		if (dat_wr) begin
			lo_byte <= word.dat.lo;
			hi_byte <= word.dat.hi;
		end
	end

	assign cd_wr   = (state == S_STROBE);
	assign cd_byte = '{data: (byte_sel ? hi_byte : lo_byte), dm: dm};

endmodule

// File: rtl/cheat_code_assembler.sv
/*
 * Cheat code assembler, eight host words form one record
 */
`timescale 1ns/10ps
`include "pce_loader_settings.svh"

module cheat_code_assembler (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  pce_loader_pkg::ioctl_bus_t  ioctl,
	output pce_loader_pkg::cheat_code_t cheat_code,
	output logic                        cheat_valid,
	output logic                        cheat_clear
);

	logic code_download;
	logic cart_download;
	logic code_wr;
	logic clear_hit;

	assign code_download = ioctl.download && (ioctl.index == `LDR_IDX_CODE);
	assign cart_download = ioctl.download && (ioctl.index[5:0] <= `LDR_IDX_CART_MAX);
	assign code_wr       = code_download && ioctl.wr;

	// New cartridge or new code list starts at host address 0
	assign clear_hit = (cart_download || code_download) && ioctl.wr && (ioctl.addr == '0);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			cheat_valid <= code_wr && (ioctl.addr[3:0] == 4'd14);
			cheat_clear <= clear_hit;
		end
	end

	// Bottom word at the even offset, top word at the next
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ioctl.addr[3:0])
				4'd0:  cheat_code.flags[15:0]    <= ioctl.dout;
				4'd2:  cheat_code.flags[31:16]   <= ioctl.dout;
				4'd4:  cheat_code.addr[15:0]     <= ioctl.dout;
				4'd6:  cheat_code.addr[31:16]    <= ioctl.dout;
				4'd8:  cheat_code.compare[15:0]  <= ioctl.dout;
				4'd10: cheat_code.compare[31:16] <= ioctl.dout;
				4'd12: cheat_code.replace[15:0]  <= ioctl.dout;
				4'd14: cheat_code.replace[31:16] <= ioctl.dout;
				default: ;
			endcase
		end
	end

endmodule

// File: rtl/pce_loader.sv
/*
 * Loader top: routes the host word bus to the ROM writer,
 * the cheat assembler and the CD data unpacker
 */
`timescale 1ns/10ps

module pce_loader (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  pce_loader_pkg::ioctl_bus_t  ioctl,
	input  logic                        rom_swap,
	input  logic                        rom_wr_ack,
	output logic                        ioctl_wait,
	output pce_loader_pkg::rom_wr_t     rom_wr,
	output pce_loader_pkg::rom_info_t   rom_info,
	output pce_loader_pkg::cheat_code_t cheat_code,
	output logic                        cheat_valid,
	output logic                        cheat_clear,
	output pce_loader_pkg::cd_byte_t    cd_byte,
	output logic                        cd_wr
);

	////////////////////////////////////////
	// Cartridge images
	////////////////////////////////////////

	rom_writer u_rom_writer (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ioctl      (ioctl),
		.rom_swap   (rom_swap),
		.rom_wr_ack (rom_wr_ack),
		.ioctl_wait (ioctl_wait),
		.rom_wr     (rom_wr),
		.rom_info   (rom_info)
	);

	////////////////////////////////////////
	// Cheat codes
	////////////////////////////////////////

	cheat_code_assembler u_cheat_code_assembler (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ioctl       (ioctl),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid),
		.cheat_clear (cheat_clear)
	);

	////////////////////////////////////////
	// CD data sectors
	////////////////////////////////////////

	// No back-pressure, host spaces its words
	cd_data_unpacker u_cd_data_unpacker (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ioctl   (ioctl),
		.cd_byte (cd_byte),
		.cd_wr   (cd_wr)
	);

endmodule

// File: rtl/pce_loader_pkg.sv
/*
 * Loader types shared by the host bus, ROM port, cheat and CD paths
 */
`include "pce_loader_settings.svh"

package pce_loader_pkg;

	// Host word bus, 51 bits
	typedef struct packed {
		logic                         download;
		logic [7:0]                   index;
		logic                         wr;
		logic [`LDR_IOCTL_ADDR_W-1:0] addr;
		logic [`LDR_WORD_W-1:0]       dout;
	} ioctl_bus_t;

	// ROM write port, req is a toggle
	typedef struct packed {
		logic                       req;
		logic [`LDR_ROM_ADDR_W-1:0] addr;
		logic [`LDR_WORD_W-1:0]     data;
	} rom_wr_t;

	typedef struct packed {
		logic [1:0]  populous;
		logic        sgx;
		logic [11:0] size_4k;
	} rom_info_t;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	// First CD word is a header, the rest carry two bytes
	typedef union packed {
		struct packed {
			logic                     dm;
			logic [`LDR_CD_LEN_W-1:0] len;
		} hdr;
		struct packed {
			logic [7:0] hi;
			logic [7:0] lo;
		} dat;
	} cd_word_u;

	typedef struct packed {
		logic [7:0] data;
		logic       dm;
	} cd_byte_t;

endpackage

// File: rtl/pce_loader_settings.svh
/*
 * Loader constants: bus widths, host file indices and the
 * Populous signature location and contents
 */
`ifndef PCE_LOADER_SETTINGS_SVH
`define PCE_LOADER_SETTINGS_SVH

// Host bus widths
`define LDR_WORD_W        16
`define LDR_IOCTL_ADDR_W  25

// ROM write port byte address
`define LDR_ROM_ADDR_W    24

// File indices, low six bits for cart and CD
`define LDR_IDX_CART_MAX  6'd1
`define LDR_IDX_CD_DATA   6'd2
`define LDR_IDX_CODE      8'hFF

// Signature rows on ROM address bits 23:4
`define LDR_SIG_ROW_A     20'h00212
`define LDR_SIG_ROW_B     20'h001F2

// Expected words at row offsets 6, 8, 10, 12
`define LDR_SIG_WORD_0    16'h4F50
`define LDR_SIG_WORD_1    16'h5550
`define LDR_SIG_WORD_2    16'h4F4C
`define LDR_SIG_WORD_3    16'h5355

// CD download header byte count
`define LDR_CD_LEN_W      15

`endif

// File: rtl/populous_detect.sv
/*
 * Populous signature check on both ROM banks during a cartridge load
 */
`timescale 1ns/10ps
`include "pce_loader_settings.svh"

module populous_detect (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       load_start,
	input  logic                       word_ok,
	input  logic [`LDR_ROM_ADDR_W-1:0] rom_addr,
	input  logic [`LDR_WORD_W-1:0]     rom_data,
	output logic [1:0]                 populous
);

	logic                   sig_row;
	logic                   sig_slot;
	logic [`LDR_WORD_W-1:0] sig_word;
	logic                   bank;

	assign sig_row = (rom_addr[`LDR_ROM_ADDR_W-1:4] == `LDR_SIG_ROW_A) ||
		(rom_addr[`LDR_ROM_ADDR_W-1:4] == `LDR_SIG_ROW_B);

	// Bank select follows address bit 13
	assign bank = rom_addr[13];

	always_comb begin
		sig_slot = 1'b1;
		sig_word = `LDR_SIG_WORD_0;
		case (rom_addr[3:0])
			4'd6:    sig_word = `LDR_SIG_WORD_0;
			4'd8:    sig_word = `LDR_SIG_WORD_1;
			4'd10:   sig_word = `LDR_SIG_WORD_2;
			4'd12:   sig_word = `LDR_SIG_WORD_3;
			default: sig_slot = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			populous <= 2'b00;
		end else if (load_start) begin
			populous <= 2'b11;
		end else if (word_ok && sig_row && sig_slot && (rom_data != sig_word)) begin
			// One bad word rules the bank out
			populous[bank] <= 1'b0;
		end
	end

endmodule

// File: rtl/rom_writer.sv
/*
 * Cartridge ROM writer: address counter, optional bit swap,
 * toggle write handshake with host wait, SuperGrafx latch
 */
`timescale 1ns/10ps
`include "pce_loader_settings.svh"

module rom_writer (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  pce_loader_pkg::ioctl_bus_t ioctl,
	input  logic                       rom_swap,
	input  logic                       rom_wr_ack,
	output logic                       ioctl_wait,
	output pce_loader_pkg::rom_wr_t    rom_wr,
	output pce_loader_pkg::rom_info_t  rom_info
);

	logic                       cart_download;
	logic                       cart_download_d;
	logic                       load_start;
	logic                       word_ok;
	logic [`LDR_WORD_W-1:0]     swapped;
	logic [`LDR_WORD_W-1:0]     wr_data;
	logic [`LDR_WORD_W-1:0]     data_q;
	logic [`LDR_ROM_ADDR_W-1:0] wr_addr;
	logic                       wr_req;
	logic                       sgx;
	logic [1:0]                 populous;

	////////////////////////////////////////
	// Load decode
	////////////////////////////////////////

	assign cart_download = ioctl.download && (ioctl.index[5:0] <= `LDR_IDX_CART_MAX);
	assign load_start    = cart_download && !cart_download_d;
	assign word_ok       = cart_download && ioctl.wr && !load_start;

	// Reverse the bit order inside each byte
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			swapped[i]     = ioctl.dout[7 - i];
			swapped[8 + i] = ioctl.dout[15 - i];
		end
	end

	assign wr_data = rom_swap ? swapped : ioctl.dout;

	////////////////////////////////////////
	// Toggle handshake and address
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_download_d <= 1'b0;
			ioctl_wait      <= 1'b0;
			wr_req          <= 1'b0;
			wr_addr         <= '0;
			sgx             <= 1'b0;
		end else begin
			cart_download_d <= cart_download;
			if (load_start) begin
				wr_addr <= '0;
				sgx     <= ioctl.index[0];
			end else if (word_ok) begin
				ioctl_wait <= 1'b1;
				wr_req     <= ~wr_req;
			end else if (ioctl_wait && (rom_wr_ack == wr_req)) begin
				// Memory has taken the word
				ioctl_wait <= 1'b0;
				wr_addr    <= wr_addr + `LDR_ROM_ADDR_W'(2);
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (word_ok) begin
			data_q <= wr_data;
		end
	end

	populous_detect u_populous_detect (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.load_start (load_start),
		.word_ok    (word_ok),
		.rom_addr   (wr_addr),
		.rom_data   (wr_data),
		.populous   (populous)
	);

	assign rom_wr   = '{req: wr_req, addr: wr_addr, data: data_q};
	assign rom_info = '{populous: populous, sgx: sgx, size_4k: wr_addr[23:12]};

endmodule

// File: sim/loader_model.svh
/*
 * Reference model for the loader testbench: bit swap,
 * Populous signature flags and cheat record layout
 */
`ifndef LOADER_MODEL_SVH
`define LOADER_MODEL_SVH

// Mirror each byte end to end, bytes keep their place
function automatic logic [15:0] bit_swap(input logic [15:0] w);
	logic [15:0] r;
	for (int b = 0; b < 16; b++) begin
		r[b] = w[(b / 8) * 8 + 7 - (b % 8)];
	end
	return r;
endfunction

function automatic logic is_sig_row(input logic [23:0] addr);
	return (addr[23:4] == `LDR_SIG_ROW_A) || (addr[23:4] == `LDR_SIG_ROW_B);
endfunction

// Signature words sit at even offsets 6 through 12
function automatic logic is_sig_offset(input logic [3:0] offset);
	return (offset[0] == 1'b0) && (offset >= 4'd6) && (offset <= 4'd12);
endfunction

function automatic logic [15:0] signature_word(input logic [3:0] offset);
	logic [63:0] words;
	int          slot;
	words = {`LDR_SIG_WORD_3, `LDR_SIG_WORD_2, `LDR_SIG_WORD_1, `LDR_SIG_WORD_0};
	slot  = (int'(offset) - 6) / 2;
	return words[slot * 16 +: 16];
endfunction

// Flags after one more written word, bank from address bit 13
function automatic logic [1:0] populous_update(input logic [1:0] flags,
	input logic [23:0] addr, input logic [15:0] data);
	logic [1:0] next;
	next = flags;
	if (is_sig_row(addr) && is_sig_offset(addr[3:0]) && (data != signature_word(addr[3:0]))) begin
		next[addr[13]] = 1'b0;
	end
	return next;
endfunction

// Word i of the record lives at bits 16*i, low half of each field first
function automatic pce_loader_pkg::cheat_code_t cheat_record(input logic [127:0] words);
	pce_loader_pkg::cheat_code_t rec;
	rec.flags   = words[31:0];
	rec.addr    = words[63:32];
	rec.compare = words[95:64];
	rec.replace = words[127:96];
	return rec;
endfunction

`endif

// File: sim/tb_pce_loader.sv
/*
 * Testbench for the loader path covering cartridge, Populous, cheat and CD loads
 */
`timescale 1ns/10ps
`include "pce_loader_settings.svh"

module tb_pce_loader;

	localparam int WAIT_LIMIT  = 64;
	localparam int DRAIN_LIMIT = 200;
	localparam int CD_GAP      = 6;

	logic                        clk_sys;
	logic                        reset;
	pce_loader_pkg::ioctl_bus_t  ioctl;
	logic                        rom_swap;
	logic                        rom_wr_ack;
	logic                        ioctl_wait;
	pce_loader_pkg::rom_wr_t     rom_wr;
	pce_loader_pkg::rom_info_t   rom_info;
	pce_loader_pkg::cheat_code_t cheat_code;
	logic                        cheat_valid;
	logic                        cheat_clear;
	pce_loader_pkg::cd_byte_t    cd_byte;
	logic                        cd_wr;

	integer seed        = 32'h5845;
	string  test_name   = "reset";
	int     err_value   = 0;
	int     err_other   = 0;
	int     err_timeout = 0;
	int     valid_count = 0;
	int     clear_count = 0;
	int     cd_count    = 0;

	logic [23:0]  exp_wr_addr[$];
	logic [15:0]  exp_wr_data[$];
	logic [23:0]  act_wr_addr[$];
	logic [15:0]  act_wr_data[$];
	logic [8:0]   exp_cd[$];
	logic [8:0]   act_cd[$];
	logic [127:0] exp_cheat[$];
	logic [127:0] act_cheat[$];

	`include "loader_model.svh"

	pce_loader u_pce_loader (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ioctl       (ioctl),
		.rom_swap    (rom_swap),
		.rom_wr_ack  (rom_wr_ack),
		.ioctl_wait  (ioctl_wait),
		.rom_wr      (rom_wr),
		.rom_info    (rom_info),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid),
		.cheat_clear (cheat_clear),
		.cd_byte     (cd_byte),
		.cd_wr       (cd_wr)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////
	// Memory side and monitors
	////////////////////////////////////////

	// Memory takes each write 1 to 4 cycles after req toggles
	initial begin : mem_responder
		int delay;
		rom_wr_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (!reset && (rom_wr.req !== rom_wr_ack)) begin
				delay = 1 + ($unsigned($random(seed)) % 4);
				repeat (delay) @(posedge clk_sys);
				#1;
				// Address and data must still be held when the ack goes back
				act_wr_addr.push_back(rom_wr.addr);
				act_wr_data.push_back(rom_wr.data);
				rom_wr_ack = rom_wr.req;
			end
		end
	end

	always @(negedge clk_sys) begin
		if (!reset) begin
			if (cheat_valid) begin
				valid_count++;
				act_cheat.push_back(cheat_code);
			end
			if (cheat_clear) begin
				clear_count++;
			end
			if (cd_wr) begin
				cd_count++;
				act_cd.push_back(cd_byte);
			end
			// Host must be held off while a write is pending
			if ((rom_wr.req != rom_wr_ack) && !ioctl_wait) begin
				$display("In %s ioctl_wait was low while a ROM write was pending", test_name);
				err_other++;
			end
		end
	end

	task automatic report_mismatch(input string what, input logic [127:0] want,
		input logic [127:0] got);
		$display("CHECK FAILED %s: %s expected %0h actual %0h", test_name, what, want, got);
		err_value++;
	endtask

	always @(posedge clk_sys) begin : compare_results
		logic [23:0]  got_addr;
		logic [15:0]  got_data;
		logic [8:0]   got_byte;
		logic [127:0] got_rec;
		while (act_wr_addr.size() > 0) begin
			got_addr = act_wr_addr.pop_front();
			got_data = act_wr_data.pop_front();
			if (exp_wr_addr.size() == 0) begin
				$display("In %s an unexpected ROM write reached address %h", test_name, got_addr);
				err_other++;
			end else begin
				if (got_addr !== exp_wr_addr[0]) begin
					report_mismatch("ROM write address", exp_wr_addr[0], got_addr);
				end
				if (got_data !== exp_wr_data[0]) begin
					report_mismatch("ROM write data", exp_wr_data[0], got_data);
				end
				void'(exp_wr_addr.pop_front());
				void'(exp_wr_data.pop_front());
			end
		end
		while (act_cd.size() > 0) begin
			got_byte = act_cd.pop_front();
			if (exp_cd.size() == 0) begin
				$display("In %s the unpacker wrote one CD byte too many", test_name);
				err_other++;
			end else if (got_byte !== exp_cd[0]) begin
				report_mismatch("CD byte and dm", exp_cd.pop_front(), got_byte);
			end else begin
				void'(exp_cd.pop_front());
			end
		end
		while (act_cheat.size() > 0) begin
			got_rec = act_cheat.pop_front();
			if (exp_cheat.size() == 0) begin
				$display("In %s cheat_valid pulsed with no record expected", test_name);
				err_other++;
			end else if (got_rec !== exp_cheat[0]) begin
				report_mismatch("cheat record", exp_cheat.pop_front(), got_rec);
			end else begin
				void'(exp_cheat.pop_front());
			end
		end
	end

	////////////////////////////////////////
	// Host bus tasks
	////////////////////////////////////////

	function automatic logic outstanding();
		return (exp_wr_addr.size() + act_wr_addr.size() + exp_cd.size() + act_cd.size() +
			exp_cheat.size() + act_cheat.size()) != 0;
	endfunction

	task automatic start_download(input logic [7:0] idx);
		valid_count = 0;
		clear_count = 0;
		cd_count    = 0;
		@(posedge clk_sys);
		#1;
		ioctl.download = 1'b1;
		ioctl.index    = idx;
		ioctl.wr       = 1'b0;
		ioctl.addr     = '0;
		@(posedge clk_sys);
		#1;
	endtask

	task automatic end_download();
		@(posedge clk_sys);
		#1;
		ioctl.download = 1'b0;
		@(posedge clk_sys);
		#1;
	endtask

	// Returns just after the edge that takes the word
	task automatic send_word(input logic [24:0] addr, input logic [15:0] data);
		@(posedge clk_sys);
		#1;
		ioctl.wr   = 1'b1;
		ioctl.addr = addr;
		ioctl.dout = data;
		@(posedge clk_sys);
		#1;
		ioctl.wr = 1'b0;
	endtask

	task automatic wait_ready(output logic ok);
		int cycles;
		cycles = 0;
		while ((ioctl_wait !== 1'b0) && (cycles < WAIT_LIMIT)) begin
			@(posedge clk_sys);
			#1;
			cycles++;
		end
		ok = (ioctl_wait === 1'b0);
		if (!ok) begin
			$display("Timeout in %s: ioctl_wait stayed high for %0d cycles", test_name, WAIT_LIMIT);
			err_timeout++;
		end
	endtask

	// Every expected item arrives before a quiet spell for stray ones
	task automatic wait_drained();
		int cycles;
		cycles = 0;
		while (outstanding() && (cycles < DRAIN_LIMIT)) begin
			@(posedge clk_sys);
			#1;
			cycles++;
		end
		if (outstanding()) begin
			$display("Timeout in %s: %0d ROM writes, %0d CD bytes, %0d cheat records missing",
				test_name, exp_wr_addr.size(), exp_cd.size(), exp_cheat.size());
			err_timeout++;
			exp_wr_addr.delete();
			exp_wr_data.delete();
			exp_cd.delete();
			exp_cheat.delete();
		end
		repeat (10) @(posedge clk_sys);
		#1;
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic load_cartridge(input logic [7:0] idx, input int n_words,
		input logic swap, input logic sig_image);
		logic [15:0] w;
		logic [15:0] wd;
		logic [23:0] a;
		logic [1:0]  flags;
		logic        ok;
		int          i;
		flags    = 2'b11;
		rom_swap = swap;
		start_download(idx);
		for (i = 0; i < n_words; i++) begin
			a = 24'(2 * i);
			w = 16'($random(seed));
			if (sig_image && is_sig_row(a) && is_sig_offset(a[3:0])) begin
				w = signature_word(a[3:0]);
				// Spoil one word in the low bank row
				if ((a[23:4] == `LDR_SIG_ROW_B) && (a[3:0] == 4'd10)) begin
					w = w ^ 16'h0100;
				end
			end
			wd    = swap ? bit_swap(w) : w;
			flags = populous_update(flags, a, wd);
			exp_wr_addr.push_back(a);
			exp_wr_data.push_back(wd);
			wait_ready(ok);
			if (!ok) begin
				break;
			end
			send_word(25'(2 * i), w);
			if (ioctl_wait !== 1'b1) begin
				report_mismatch("ioctl_wait after word", 1, ioctl_wait);
			end
		end
		wait_ready(ok);
		end_download();
		wait_drained();
		if (rom_info.sgx !== idx[0]) begin
			report_mismatch("rom_info.sgx", idx[0], rom_info.sgx);
		end
		if (rom_info.size_4k !== 12'((2 * n_words) >> 12)) begin
			report_mismatch("rom_info.size_4k", (2 * n_words) >> 12, rom_info.size_4k);
		end
		if (rom_info.populous !== flags) begin
			report_mismatch("rom_info.populous", flags, rom_info.populous);
		end
		if (sig_image && (rom_info.populous !== 2'b10)) begin
			report_mismatch("populous bank flags", 2'b10, rom_info.populous);
		end
		if (clear_count != 1) begin
			report_mismatch("cheat_clear pulses", 1, clear_count);
		end
	endtask

	task automatic load_cheat();
		logic [127:0] words;
		int           i;
		for (i = 0; i < 8; i++) begin
			words[16 * i +: 16] = 16'($random(seed));
		end
		exp_cheat.push_back(cheat_record(words));
		start_download(`LDR_IDX_CODE);
		for (i = 0; i < 8; i++) begin
			send_word(25'(2 * i), words[16 * i +: 16]);
		end
		end_download();
		wait_drained();
		if (valid_count != 1) begin
			report_mismatch("cheat_valid pulses", 1, valid_count);
		end
		if (clear_count != 1) begin
			report_mismatch("cheat_clear pulses", 1, clear_count);
		end
	endtask

	task automatic load_cd(input logic [14:0] len);
		logic [15:0] w;
		int          n_words;
		int          i;
		// The extra word past len must yield no byte
		n_words = (int'(len) + 1) / 2 + 1;
		start_download({2'b00, `LDR_IDX_CD_DATA});
		send_word(25'd0, {1'b1, len});
		repeat (CD_GAP) @(posedge clk_sys);
		for (i = 0; i < n_words; i++) begin
			w = 16'($random(seed));
			if (2 * i < int'(len)) begin
				exp_cd.push_back({w[7:0], 1'b1});
			end
			if (2 * i + 1 < int'(len)) begin
				exp_cd.push_back({w[15:8], 1'b1});
			end
			send_word(25'(2 * i + 2), w);
			repeat (CD_GAP) @(posedge clk_sys);
		end
		end_download();
		wait_drained();
		if (cd_count != int'(len)) begin
			report_mismatch("cd_wr strobes", len, cd_count);
		end
		if (clear_count != 0) begin
			report_mismatch("cheat_clear pulses", 0, clear_count);
		end
	endtask

	initial begin : main
		ioctl    = '0;
		rom_swap = 1'b0;
		reset    = 1'b1;
		repeat (2) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		repeat (2) @(posedge clk_sys);
		#1;

		test_name = "cart_plain";
		load_cartridge(8'h00, 2064, 1'b0, 1'b0);
		test_name = "cart_swap";
		load_cartridge(8'h01, 300, 1'b1, 1'b0);
		test_name = "populous";
		load_cartridge(8'h00, 4248, 1'b0, 1'b1);
		test_name = "cheat";
		load_cheat();
		test_name = "cd_data";
		load_cd(15'd23);

		$display("Errors: %0d value, %0d protocol, %0d timeout", err_value, err_other,
			err_timeout);
		if ((err_value == 0) && (err_other == 0) && (err_timeout == 0)) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule
